// ==== compile.f ====
+incdir+hdl
hdl/cpu_decode_pkg.sv
hdl/cycle_decoder.sv
hdl/class_decoder.sv
hdl/decode_status.sv
hdl/cpu_decode_top.sv
testbench/tb_cpu_decode.sv

// ==== Bender.yml ====
package:
  name: cpu_decode

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cpu_decode_pkg.sv
      - hdl/cycle_decoder.sv
      - hdl/class_decoder.sv
      - hdl/decode_status.sv
      - hdl/cpu_decode_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_cpu_decode.sv

// ==== testbench/tb_cpu_decode.sv ====
`include "cpu_decode_defs.svh"

module tb_cpu_decode;

	localparam int PERIOD     = 100; // clock period
	localparam int RESET_CYC  = 16;
	localparam int N_CYC_OPS  = 32; // cycle mask opcodes
	localparam int N_CLS_OPS  = 8; // class flag opcodes
	localparam int FLAG_N     = 4; // random flag draws per condition
	localparam int ALE_N      = 12; // half-cycle steps
	localparam int HOLD_N     = 10; // bus changes with strobe low
	localparam int SWEEP_N    = 96; // random opcodes against model
	// three cycles per opcode load, one per flag, level or bus step
	localparam int RUN_CYC    = RESET_CYC + 1 + 3 * N_CYC_OPS + 3 * N_CLS_OPS +
		8 * (3 + 2 * FLAG_N) + ALE_N + 3 + 3 + HOLD_N + 3 * SWEEP_N;
	localparam int MARGIN_CYC = 50;

	// one or more opcodes per cycle group, listed in test order
	localparam logic [8*N_CYC_OPS-1:0] CYC_OPS = {
		8'h3E, 8'h0A, 8'h12, 8'hC6, 8'h77, 8'h7E, 8'h86, 8'h76, // 2 cycles
		8'hC0, 8'hC2, 8'hFF, 8'hC5, 8'hE1, 8'hC3, 8'hC9, 8'h09, // 3 cycles
		8'h21, 8'h34, 8'h35, 8'h36, 8'hDB, 8'hD3,
		8'h32, 8'h3A, // 4 cycles
		8'hC4, 8'hE3, 8'hCD, 8'h22, 8'h2A, // 5 cycles
		8'h00, 8'h47, 8'h03 // single cycle
	};
	localparam logic [8*N_CLS_OPS-1:0] CLS_OPS = {
		8'h76, 8'h09, 8'hD3, 8'hDB, 8'hC5, 8'hCD, 8'hE9, 8'h78
	};
	// expected {go6, dad, hlt, dio} per class opcode
	localparam logic [4*N_CLS_OPS-1:0] CLS_EXP = {
		4'b0010, 4'b0100, 4'b0001, 4'b0001, 4'b1000, 4'b1000, 4'b1000, 4'b0000
	};

	logic                    clk = 1'b0;
	logic                    rst_;
	logic                    i_code_en;
	logic [`CD_DATA_W-1:0]   i_bus_d;
	logic                    i_ale;
	logic                    i_third;
	logic [`CD_DATA_W-1:0]   i_flags;
	cpu_decode_pkg::status_t o_status;
	logic [31:0]             seed; // lcg state
	logic [7:0]              op_q; // opcode last loaded

	cpu_decode_top u_dut (
		.clk       (clk),
		.rst_      (rst_),
		.i_code_en (i_code_en),
		.i_bus_d   (i_bus_d),
		.i_ale     (i_ale),
		.i_third   (i_third),
		.i_flags   (i_flags),
		.o_status  (o_status)
	);

	always #(PERIOD / 2) clk = ~clk;

	function automatic logic [7:0] rand_byte();
		seed = seed * 32'd1664525 + 32'd1013904223; // numerical recipes lcg
		return seed[23:16];
	endfunction

	// op agrees with val on the bits set in care
	function automatic logic fits(input logic [7:0] op, input logic [7:0] val,
		input logic [7:0] care);
		return (op & care) == (val & care);
	endfunction

	// expected status word, built from the instruction tables
	function automatic cpu_decode_pkg::status_t model_status(input logic [7:0] op,
		input logic [7:0] flags, input logic ale_lvl, input logic ctl_lvl);
		cpu_decode_pkg::status_t s;
		logic hlt, mvi_r, ldax, stax, ali, mov_from_m, mov_to_m, alu_m;
		logic rcc, jcc, rst_n, push, pop, lxi, dad, rmw, mvi_m, io_in, io_out;
		logic sta, lda, ccl, xthl, call, shld, lhld;
		logic c2, c3, c4, c5;
		s          = '0;
		hlt        = (op == 8'h76);
		mvi_r      = fits(op, 8'h06, 8'hC7) && (op != 8'h36); // 00ddd110
		ldax       = (op == 8'h0A) || (op == 8'h1A);
		stax       = (op == 8'h02) || (op == 8'h12);
		ali        = fits(op, 8'hC6, 8'hC7); // adi..cpi
		mov_from_m = fits(op, 8'h46, 8'hC7) && !hlt; // mov r,m
		mov_to_m   = fits(op, 8'h70, 8'hF8) && !hlt; // mov m,r
		alu_m      = fits(op, 8'h86, 8'hC7);
		rcc        = fits(op, 8'hC0, 8'hC7);
		jcc        = fits(op, 8'hC2, 8'hC7);
		rst_n      = fits(op, 8'hC7, 8'hC7);
		push       = fits(op, 8'hC5, 8'hCF);
		pop        = fits(op, 8'hC1, 8'hCF);
		lxi        = fits(op, 8'h01, 8'hCF);
		dad        = fits(op, 8'h09, 8'hCF);
		rmw        = (op == 8'h34) || (op == 8'h35); // inr m, dcr m
		mvi_m      = (op == 8'h36);
		io_in      = (op == 8'hDB);
		io_out     = (op == 8'hD3);
		sta        = (op == 8'h32);
		lda        = (op == 8'h3A);
		ccl        = fits(op, 8'hC4, 8'hC7); // conditional call
		xthl       = (op == 8'hE3);
		call       = (op == 8'hCD);
		shld       = (op == 8'h22);
		lhld       = (op == 8'h2A);
		c2 = mvi_r | ldax | stax | ali | mov_from_m | mov_to_m | alu_m | hlt;
		c3 = rcc | jcc | rst_n | push | pop | (op == 8'hC3) | (op == 8'hC9) |
			dad | lxi | rmw | mvi_m | io_in | io_out;
		c4 = sta | lda;
		c5 = ccl | xthl | call | shld | lhld;
		if (c2) begin
			s.cyc_go = 4'b0001;
		end else if (c3) begin
			s.cyc_go = 4'b0011;
		end else if (c4) begin
			s.cyc_go = 4'b0111;
		end else if (c5) begin
			s.cyc_go = 4'b1111;
		end
		s.cyc_rw[0] = stax | rst_n | push | mov_to_m;
		s.cyc_rw[1] = mvi_m | rmw | rst_n | push | io_out;
		s.cyc_rw[2] = ccl | xthl | call | shld | sta;
		s.cyc_rw[3] = ccl | xthl | call | shld;
		s.cyc_cd[0] = ldax | stax | rmw | mov_from_m | mov_to_m | alu_m;
		s.cyc_cd[1] = mvi_m | rmw;
		s.hlt = hlt;
		s.dad = dad;
		s.dio = io_in | io_out;
		s.go6 = fits(op, 8'h03, 8'hC7) | rst_n | rcc | ccl | push | // inx, dcx
			(op == 8'hE9) | (op == 8'hF9) | call;
		case (op[5:3]) // condition code table
			3'd0: s.ccc = !flags[`CD_FLAG_Z];
			3'd1: s.ccc = flags[`CD_FLAG_Z];
			3'd2: s.ccc = !flags[`CD_FLAG_C];
			3'd3: s.ccc = flags[`CD_FLAG_C];
			3'd4: s.ccc = !flags[`CD_FLAG_P];
			3'd5: s.ccc = flags[`CD_FLAG_P];
			3'd6: s.ccc = !flags[`CD_FLAG_S];
			default: s.ccc = flags[`CD_FLAG_S];
		endcase
		s.ale = ale_lvl;
		s.ctl = ctl_lvl;
		return s;
	endfunction

	task automatic abort_run(input string why);
		$display("Result: FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_status(input string name, input cpu_decode_pkg::status_t exp,
		input cpu_decode_pkg::status_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			abort_run("status word mismatch");
		end
	endtask

	task automatic check_mask(input string name, input cpu_decode_pkg::cyc_mask_t exp,
		input cpu_decode_pkg::cyc_mask_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s expected %b actual %b", name, exp, act);
			abort_run("cycle mask mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED %s expected %b actual %b", name, exp, act);
			abort_run("status bit mismatch");
		end
	endtask

	// strobe op into the ir, return at the following falling edge
	task automatic load_op(input logic [7:0] op);
		@(posedge clk);
		i_code_en <= 1'b1;
		i_bus_d   <= op;
		@(posedge clk); // ir takes op here
		i_code_en <= 1'b0;
		op_q = op;
		@(negedge clk);
	endtask

	task automatic test_reset();
		@(negedge clk);
		check_mask("reset go", 4'b0000, o_status.cyc_go);
		check_mask("reset rw", 4'b0000, o_status.cyc_rw);
		check_mask("reset cd", 4'b0000, o_status.cyc_cd);
		check_bit("reset go6", 1'b0, o_status.go6);
		check_bit("reset dad", 1'b0, o_status.dad);
		check_bit("reset hlt", 1'b0, o_status.hlt);
		check_bit("reset dio", 1'b0, o_status.dio);
		check_bit("reset ale", 1'b1, o_status.ale);
		check_bit("reset ctl", 1'b0, o_status.ctl);
		check_status("reset word", model_status(8'h00, i_flags, 1'b1, 1'b0), o_status);
	endtask

	task automatic test_cycle_masks();
		cpu_decode_pkg::status_t exp;
		logic [7:0] op;
		string name;
		for (int i = 0; i < N_CYC_OPS; i++) begin
			op = CYC_OPS[8*(N_CYC_OPS-1-i) +: 8];
			load_op(op);
			exp  = model_status(op, i_flags, ~i_ale, i_third);
			name = $sformatf("cycle masks op %h", op);
			check_mask({name, " go"}, exp.cyc_go, o_status.cyc_go);
			check_mask({name, " rw"}, exp.cyc_rw, o_status.cyc_rw);
			check_mask({name, " cd"}, exp.cyc_cd, o_status.cyc_cd);
		end
	endtask

	task automatic test_class_flags();
		logic [7:0] op;
		logic [3:0] exp; // go6, dad, hlt, dio
		string name;
		for (int i = 0; i < N_CLS_OPS; i++) begin
			op  = CLS_OPS[8*(N_CLS_OPS-1-i) +: 8];
			exp = CLS_EXP[4*(N_CLS_OPS-1-i) +: 4];
			load_op(op);
			name = $sformatf("class flags op %h", op);
			check_bit({name, " go6"}, exp[3], o_status.go6);
			check_bit({name, " dad"}, exp[2], o_status.dad);
			check_bit({name, " hlt"}, exp[1], o_status.hlt);
			check_bit({name, " dio"}, exp[0], o_status.dio);
		end
	endtask

	task automatic test_condition();
		cpu_decode_pkg::status_t exp;
		logic [7:0] op;
		logic [7:0] f;
		f = '0;
		for (int cc = 0; cc < 8; cc++) begin
			op = {2'b11, cc[2:0], 3'b010}; // jccc
			load_op(op);
			for (int k = 0; k < 2 * FLAG_N; k++) begin
				if (k % 2 == 0) begin
					f = rand_byte();
				end else begin
					f = ~f; // other polarity of the same draw
				end
				@(posedge clk);
				i_flags <= f;
				@(negedge clk); // ccc follows flags with no clock
				exp = model_status(op, f, ~i_ale, i_third);
				check_bit($sformatf("condition op %h flags %h", op, f), exp.ccc, o_status.ccc);
			end
		end
	endtask

	task automatic test_half_cycles();
		logic [7:0] r;
		logic prev_ale;
		logic prev_third;
		prev_ale   = i_ale;
		prev_third = i_third;
		for (int k = 0; k < ALE_N; k++) begin
			r = rand_byte();
			@(posedge clk); // flops take the previous levels here
			i_ale   <= ~prev_ale;
			i_third <= r[1];
			@(negedge clk);
			check_bit("half cycle ale", ~prev_ale, o_status.ale);
			check_bit("half cycle ctl", prev_third, o_status.ctl);
			prev_ale   = ~prev_ale;
			prev_third = r[1];
		end
		@(posedge clk);
		i_ale   <= 1'b0;
		i_third <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_bit("half cycle idle ale", 1'b1, o_status.ale);
		check_bit("half cycle idle ctl", 1'b0, o_status.ctl);
	endtask

	task automatic test_hold();
		cpu_decode_pkg::status_t exp;
		logic [7:0] b;
		load_op(8'hCD);
		for (int k = 0; k < HOLD_N; k++) begin
			b = rand_byte();
			@(posedge clk);
			i_bus_d <= b; // strobe stays low
			@(negedge clk);
			exp = model_status(op_q, i_flags, ~i_ale, i_third);
			check_status($sformatf("hold bus %h", b), exp, o_status);
		end
	endtask

	task automatic test_sweep();
		cpu_decode_pkg::status_t exp;
		logic [7:0] op;
		logic [7:0] f;
		logic [7:0] r;
		for (int k = 0; k < SWEEP_N; k++) begin
			op = rand_byte();
			f  = rand_byte();
			r  = rand_byte();
			@(posedge clk);
			i_code_en <= 1'b1;
			i_bus_d   <= op;
			i_flags   <= f;
			i_ale     <= r[0];
			i_third   <= r[1];
			@(posedge clk); // ir and half cycles load
			i_code_en <= 1'b0;
			@(negedge clk);
			exp = model_status(op, f, ~r[0], r[1]);
			check_status($sformatf("sweep op %h flags %h", op, f), exp, o_status);
		end
	endtask

	initial begin
		rst_      = 1'b1;
		i_code_en = 1'b0;
		i_bus_d   = '0;
		i_ale     = 1'b0;
		i_third   = 1'b0;
		i_flags   = '0;
		seed      = 32'h2a220fb6;
		op_q      = 8'h00;
		repeat (RESET_CYC) @(posedge clk);
		rst_ <= 1'b0;
		test_reset();
		test_cycle_masks();
		test_class_flags();
		test_condition();
		test_half_cycles();
		test_hold();
		test_sweep();
		$display("Result: PASSED");
		$finish;
	end

	// bound on the whole run
	initial begin
		#(PERIOD * (RUN_CYC + MARGIN_CYC));
		$display("timeout: tests did not finish within %0d cycles", RUN_CYC + MARGIN_CYC);
		abort_run("watchdog timeout");
	end

endmodule

// ==== hdl/cpu_decode_top.sv ====
`include "cpu_decode_defs.svh"

module cpu_decode_top (
	input  logic                    clk,
	input  logic                    rst_,
	input  logic                    i_code_en, // load opcode strobe
	input  logic [`CD_DATA_W-1:0]   i_bus_d,   // data bus
	input  logic                    i_ale,     // bus ale request
	input  logic                    i_third,   // third-state control
	input  logic [`CD_DATA_W-1:0]   i_flags,   // flag register value
	output cpu_decode_pkg::status_t o_status   // to control unit
);

	cpu_decode_pkg::opcode_u   opcode; // latched instruction
	cpu_decode_pkg::cyc_mask_t cyc_go, cyc_rw, cyc_cd; // cycle masks
	logic go6, dad, hlt, dio; // class flags
	logic [2:0] cond_sel; // condition code

	// ir, half cycles, condition, status assembly
	decode_status u_status (
		.clk        (clk),
		.rst_       (rst_),
		.i_code_en  (i_code_en),
		.i_bus_d    (i_bus_d),
		.i_ale      (i_ale),
		.i_third    (i_third),
		.i_flags    (i_flags),
		.i_go6      (go6),
		.i_dad      (dad),
		.i_hlt      (hlt),
		.i_dio      (dio),
		.i_cond_sel (cond_sel),
		.i_cyc_go   (cyc_go),
		.i_cyc_rw   (cyc_rw),
		.i_cyc_cd   (cyc_cd),
		.o_opcode   (opcode),
		.o_status   (o_status)
	);

	cycle_decoder u_cycle (
		.i_opcode (opcode),
		.o_cyc_go (cyc_go),
		.o_cyc_rw (cyc_rw),
		.o_cyc_cd (cyc_cd)
	);

	class_decoder u_class (
		.i_opcode   (opcode),
		.o_go6      (go6),
		.o_dad      (dad),
		.o_hlt      (hlt),
		.o_dio      (dio),
		.o_cond_sel (cond_sel)
	);

endmodule

// ==== hdl/decode_status.sv ====
`include "cpu_decode_defs.svh"

module decode_status (
	input  logic                      clk,
	input  logic                      rst_,
	input  logic                      i_code_en,  // load opcode strobe
	input  logic [`CD_DATA_W-1:0]     i_bus_d,    // data bus
	input  logic                      i_ale,      // bus ale request
	input  logic                      i_third,    // third-state control
	input  logic [`CD_DATA_W-1:0]     i_flags,    // flag register value
	input  logic                      i_go6,      // from class decoder
	input  logic                      i_dad,
	input  logic                      i_hlt,
	input  logic                      i_dio,
	input  logic [2:0]                i_cond_sel, // condition code
	input  cpu_decode_pkg::cyc_mask_t i_cyc_go,   // from cycle decoder
	input  cpu_decode_pkg::cyc_mask_t i_cyc_rw,
	input  cpu_decode_pkg::cyc_mask_t i_cyc_cd,
	output cpu_decode_pkg::opcode_u   o_opcode,   // instruction register
	output cpu_decode_pkg::status_t   o_status    // status word
);

	logic q_ale; // ale half-cycle level
	logic q_ctl; // third-state half-cycle level
	logic ccc; // selected condition
	logic [`CD_STATUS_W-1:0] st_w; // assembled status bits

	// instruction register, resets to nop
	always_ff @(posedge clk or posedge rst_) begin
		if (rst_) begin
			o_opcode <= '0;
		end else if (i_code_en) begin
			o_opcode <= i_bus_d; // hold when strobe low
		end
	end

	// half cycles, one clock behind the requests
	always_ff @(posedge clk or posedge rst_) begin
		if (rst_) begin
			q_ale <= 1'b1; // ale idle high here
			q_ctl <= 1'b0;
		end else begin
			q_ale <= ~i_ale; // inverted
			q_ctl <= i_third;
		end
	end

	// condition against outside flag byte, same cycle
	always_comb begin
		case (i_cond_sel)
			3'b000:  ccc = ~i_flags[`CD_FLAG_Z]; // nz
			3'b001:  ccc = i_flags[`CD_FLAG_Z]; // z
			3'b010:  ccc = ~i_flags[`CD_FLAG_C]; // nc
			3'b011:  ccc = i_flags[`CD_FLAG_C]; // c
			3'b100:  ccc = ~i_flags[`CD_FLAG_P]; // po
			3'b101:  ccc = i_flags[`CD_FLAG_P]; // pe
			3'b110:  ccc = ~i_flags[`CD_FLAG_S]; // p
			default: ccc = i_flags[`CD_FLAG_S]; // m
		endcase
	end

	// status word per control unit bit map
	always_comb begin
		st_w = '0;
		st_w[`CD_ST_GO6] = i_go6;
		st_w[`CD_ST_DAD] = i_dad;
		st_w[`CD_ST_HLT] = i_hlt;
		st_w[`CD_ST_DIO] = i_dio;
		st_w[`CD_ST_CYH:`CD_ST_CYL] = i_cyc_go; // extra machine cycles
		st_w[`CD_ST_RWH:`CD_ST_RWL] = i_cyc_rw; // write cycles
		st_w[`CD_ST_CDH:`CD_ST_CDL] = i_cyc_cd; // data pointer cycles
		st_w[`CD_ST_ALE] = q_ale;
		st_w[`CD_ST_CTL] = q_ctl;
		st_w[`CD_ST_CCC] = ccc;
	end

	assign o_status = cpu_decode_pkg::status_t'(st_w);

endmodule

// ==== hdl/class_decoder.sv ====
`include "cpu_decode_defs.svh"

module class_decoder (
	input  cpu_decode_pkg::opcode_u i_opcode,  // latched instruction
	output logic                    o_go6,     // 6-state fetch class
	output logic                    o_dad,     // double add
	output logic                    o_hlt,     // halt
	output logic                    o_dio,     // in/out
	output logic [2:0]              o_cond_sel // condition code field
);

	logic g_txa, g_sic; // group hits
	logic [2:0] src; // low field, same in both views
	logic [1:0] rp; // register pair
	logic half; // pair-half / variant bit
	logic op_xid; // inx, dcx
	logic op_rst; // rst n
	logic op_ccx; // rccc and cccc
	logic op_push; // push rp
	logic op_xhl; // pchl, sphl
	logic op_call; // unconditional call

	assign g_txa = (i_opcode.f.grp == `CD_GRP_TXA);
	assign g_sic = (i_opcode.f.grp == `CD_GRP_SIC);
	assign src   = i_opcode.f.src;
	assign rp    = i_opcode.p.rp;
	assign half  = i_opcode.p.half;

	// single opcode compare on the whole byte
	assign o_hlt = (i_opcode == `CD_DATA_W'h76);

	// dad b/d/h/sp is 00rp1001
	assign o_dad = g_txa & (src == 3'b001) & half;

	// out d3h and in dbh share pair 01 and src 011
	assign o_dio = g_sic & (src == 3'b011) & (rp == 2'b01);

	assign op_xid  = g_txa & (src == 3'b011); // 00rpx011
	assign op_rst  = g_sic & (src == 3'b111); // 11nnn111
	assign op_ccx  = g_sic & (src[1:0] == 2'b00); // 11cccx00
	assign op_push = g_sic & (src == 3'b101) & ~half; // 11rp0101
	assign op_xhl  = g_sic & (src == 3'b001) & rp[1] & half; // e9h, f9h
	assign op_call = g_sic & (src == 3'b101) & (rp == 2'b00) & half; // cdh

	// these need the extra fetch states for pair or stack work
	assign o_go6 = op_xid | op_rst | op_ccx | op_push | op_xhl | op_call;

	// ccc sits in the destination field for jccc, cccc, rccc
	assign o_cond_sel = i_opcode.f.dst;

endmodule

// ==== hdl/cycle_decoder.sv ====
`include "cpu_decode_defs.svh"

module cycle_decoder (
	input  cpu_decode_pkg::opcode_u   i_opcode, // latched instruction
	output cpu_decode_pkg::cyc_mask_t o_cyc_go, // extra cycles, thermometer
	output cpu_decode_pkg::cyc_mask_t o_cyc_rw, // write cycle per mc
	output cpu_decode_pkg::cyc_mask_t o_cyc_cd  // data pointer per mc
);

	logic [1:0] grp; // opcode fields
	logic [2:0] dst;
	logic [2:0] src;
	logic g_txa, g_mov, g_alu, g_sic; // group hits
	logic mem_d, mem_s; // memory operand as dst / src
	// single instructions or small families
	logic is_hlt, is_mvi_r, is_xax, is_stax, is_ali, is_mov_m, is_mov_to_m, is_alu_m;
	logic is_rcc, is_jcc, is_rst, is_push, is_pop, is_jmp, is_ret, is_lxd;
	logic is_rmw, is_mvi_m, is_io, is_out;
	logic is_stld, is_sta;
	logic is_ccl, is_xthl, is_call, is_hld, is_shld;
	// machine cycle groups
	logic need_2, need_3, need_4, need_5;
	// per-cycle write and data pointer terms
	logic wr_2, wr_3, wr_4, wr_5;
	logic dp_2, dp_3;

	assign grp = i_opcode.f.grp;
	assign dst = i_opcode.f.dst;
	assign src = i_opcode.f.src;

	assign g_txa = (grp == `CD_GRP_TXA);
	assign g_mov = (grp == `CD_GRP_MOV);
	assign g_alu = (grp == `CD_GRP_ALU);
	assign g_sic = (grp == `CD_GRP_SIC);
	assign mem_d = (dst == `CD_REG_M);
	assign mem_s = (src == `CD_REG_M);

	// 2-cycle family
	assign is_hlt      = g_mov & mem_d & mem_s; // 76h
	assign is_mvi_r    = g_txa & mem_s & ~mem_d; // mvi r (7)
	assign is_xax      = g_txa & (src == 3'b010) & ~dst[2]; // ldax, stax (4)
	assign is_stax     = is_xax & ~dst[0]; // stax b, d
	assign is_ali      = g_sic & mem_s; // adi..cpi (8)
	assign is_mov_m    = g_mov & (mem_d ^ mem_s); // one side is m (14)
	assign is_mov_to_m = g_mov & mem_d & ~mem_s; // mov m,r (7)
	assign is_alu_m    = g_alu & mem_s; // alu with m (8)

	// 3-cycle family
	assign is_rcc   = g_sic & (src == 3'b000); // rccc (8)
	assign is_jcc   = g_sic & (src == 3'b010); // jccc (8)
	assign is_rst   = g_sic & (src == 3'b111); // rst n (8)
	assign is_push  = g_sic & (src == 3'b101) & ~dst[0]; // push (4)
	assign is_pop   = g_sic & (src == 3'b001) & ~dst[0]; // pop (4)
	assign is_jmp   = g_sic & (src == 3'b011) & (dst == 3'b000); // c3h
	assign is_ret   = g_sic & (src == 3'b001) & (dst == 3'b001); // c9h
	assign is_lxd   = g_txa & (src == 3'b001); // dad, lxi (8)
	assign is_rmw   = g_txa & mem_d & (src[2:1] == 2'b10); // inr m, dcr m
	assign is_mvi_m = g_txa & mem_d & mem_s; // 36h
	assign is_io    = g_sic & (src == 3'b011) & (dst[2:1] == 2'b01); // out, in
	assign is_out   = is_io & ~dst[0]; // d3h

	// 4-cycle family
	assign is_stld = g_txa & (src == 3'b010) & (dst[2:1] == 2'b11); // sta, lda
	assign is_sta  = is_stld & ~dst[0]; // 32h

	// 5-cycle family
	assign is_ccl  = g_sic & (src == 3'b100); // cccc (8)
	assign is_xthl = g_sic & (src == 3'b011) & (dst == 3'b100); // e3h
	assign is_call = g_sic & (src == 3'b101) & (dst == 3'b001); // cdh
	assign is_hld  = g_txa & (src == 3'b010) & (dst[2:1] == 2'b10); // shld, lhld
	assign is_shld = is_hld & ~dst[0]; // 22h

	assign need_2 = is_mvi_r | is_xax | is_ali | is_mov_m | is_alu_m | is_hlt;
	assign need_3 = is_rcc | is_jcc | is_rst | is_push | is_pop | is_jmp | is_ret |
		is_lxd | is_rmw | is_mvi_m | is_io;
	assign need_4 = is_stld;
	assign need_5 = is_ccl | is_xthl | is_call | is_hld;

	// write cycles, mc2..mc5
	assign wr_2 = is_stax | is_rst | is_push | is_mov_to_m; // data or stack write
	assign wr_3 = is_mvi_m | is_rmw | is_rst | is_push | is_out;
	assign wr_4 = is_ccl | is_xthl | is_call | is_shld | is_sta;
	assign wr_5 = is_ccl | is_xthl | is_call | is_shld;

	// data pointer cycles, only mc2 and mc3 ever use it
	assign dp_2 = is_xax | is_rmw | is_mov_m | is_alu_m;
	assign dp_3 = is_mvi_m | is_rmw;

	// first matching group wins
	always_comb begin
		if (need_2) begin
			o_cyc_go = 4'b0001;
		end else if (need_3) begin
			o_cyc_go = 4'b0011;
		end else if (need_4) begin
			o_cyc_go = 4'b0111;
		end else if (need_5) begin
			o_cyc_go = 4'b1111;
		end else begin
			o_cyc_go = 4'b0000; // single cycle
		end
	end

	assign o_cyc_rw = {wr_5, wr_4, wr_3, wr_2};
	assign o_cyc_cd = {2'b00, dp_3, dp_2}; // mc4, mc5 never data pointer

endmodule

// ==== hdl/cpu_decode_pkg.sv ====
`include "cpu_decode_defs.svh"

package cpu_decode_pkg;

	// plain register view of the opcode
	typedef struct packed {
		logic [1:0] grp; // instruction group
		logic [2:0] dst; // destination reg or condition code
		logic [2:0] src; // source reg or sub-opcode
	} op_field_t;

	// register pair view of the same byte
	typedef struct packed {
		logic [1:0] grp;  // instruction group
		logic [1:0] rp;   // pair: bc, de, hl, sp/psw
		logic       half; // pair-half / variant select
		logic [2:0] src;  // sub-opcode
	} op_pair_t;

	// one opcode byte, two decodings
	typedef union packed {
		op_field_t f; // field view
		op_pair_t  p; // pair view
	} opcode_u;

	// bit 0 is mc2, bit 3 is mc5
	typedef logic [`CD_CYC_W-1:0] cyc_mask_t;

	// listed msb first, so go6 sits at bit 0
	typedef struct packed {
		logic      ccc;    // condition true
		logic      ctl;    // third-state level, delayed
		logic      ale;    // ale level, delayed and inverted
		cyc_mask_t cyc_cd; // data pointer cycles
		cyc_mask_t cyc_rw; // write cycles
		cyc_mask_t cyc_go; // extra machine cycles
		logic      dio;    // in/out
		logic      hlt;    // halt
		logic      dad;    // double add
		logic      go6;    // 6-state fetch
	} status_t;

endpackage

// ==== hdl/cpu_decode_defs.svh ====
`ifndef CPU_DECODE_DEFS_SVH
`define CPU_DECODE_DEFS_SVH

// widths
`define CD_DATA_W   8  // data bus and opcode
`define CD_CYC_W    4  // one bit per extra machine cycle, mc2..mc5
`define CD_STATUS_W 19 // status word seen by control unit

// status word bit map
`define CD_ST_GO6 0  // pair/stack op, 6-state fetch
`define CD_ST_DAD 1  // double add
`define CD_ST_HLT 2  // halt
`define CD_ST_DIO 3  // in/out
`define CD_ST_CYL 4  // cycle go mask, low bit
`define CD_ST_CYH 7  // cycle go mask, high bit
`define CD_ST_RWL 8  // write mask, low bit
`define CD_ST_RWH 11 // write mask, high bit
`define CD_ST_CDL 12 // data pointer mask, low bit
`define CD_ST_CDH 15 // data pointer mask, high bit
`define CD_ST_ALE 16 // registered ale level
`define CD_ST_CTL 17 // registered third-state level
`define CD_ST_CCC 18 // condition true

// flag byte bit positions
`define CD_FLAG_S 7 // sign
`define CD_FLAG_Z 6 // zero
`define CD_FLAG_P 2 // parity
`define CD_FLAG_C 0 // carry

// opcode top-two-bit groups
`define CD_GRP_TXA 2'b00 // transfer + arithmetic
`define CD_GRP_MOV 2'b01 // register move + halt
`define CD_GRP_ALU 2'b10 // alu with register
`define CD_GRP_SIC 2'b11 // stack, i/o, control

// register field code for memory operand
`define CD_REG_M 3'b110

`endif
